//--- Makefile
TOP = tb_exec_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f exec_core.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f exec_core.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir

//--- ex_alu.sv
`timescale 1ns/1ps

module ex_alu import isa_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,

  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o,

  input  logic            valid_i,
  output logic            ready_o,
  output logic            valid_o,
  input  logic            ready_i
);

  // Extended difference gives both carry and sign
  logic [XLEN:0]    diff;
  logic             lt_u;
  logic             lt_s;
  logic             eq;
  logic [SHAMT_W-1:0] shamt;

  assign diff  = {1'b0, operand_a_i} - {1'b0, operand_b_i};
  // Borrow out means a below b unsigned
  assign lt_u  = diff[XLEN];
  // Signs differ so the negative one is smaller
  assign lt_s  = (operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) ?
                 operand_a_i[XLEN-1] : diff[XLEN-1];
  assign eq    = (operand_a_i == operand_b_i);
  assign shamt = operand_b_i[SHAMT_W-1:0];

  // Arithmetic, logic and shifts
  always_comb begin
    result_o = '0;
    case (operator_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = diff[XLEN-1:0];
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      ALU_SRA:  result_o = $signed(operand_a_i) >>> shamt;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
      default:  result_o = '0;
    endcase
  end

  // Branch comparisons
  always_comb begin
    case (operator_i)
      ALU_EQ:  cmp_result_o = eq;
      ALU_NE:  cmp_result_o = !eq;
      ALU_LT:  cmp_result_o = lt_s;
      ALU_GE:  cmp_result_o = !lt_s;
      ALU_LTU: cmp_result_o = lt_u;
      ALU_GEU: cmp_result_o = !lt_u;
      default: cmp_result_o = 1'b0;
    endcase
  end

  // Single cycle, handshake passes straight through
  assign valid_o = valid_i;
  assign ready_o = ready_i;

endmodule

//--- ex_div.sv
`timescale 1ns/1ps

module ex_div import isa_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  input  div_op_e         operator_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,

  output logic [XLEN-1:0] result_o,

  input  logic            valid_i,
  output logic            ready_o,
  output logic            valid_o,
  input  logic            ready_i
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } div_state_e;

  div_state_e           state_q;
  div_state_e           state_d;
  logic [DIV_CNT_W-1:0] cnt_q;
  logic                 last;

  // Operand conditioning
  logic                 op_signed;
  logic                 a_neg;
  logic                 b_neg;
  logic [XLEN-1:0]      abs_a;
  logic [XLEN-1:0]      abs_b;
  logic                 div_zero;

  // Iteration datapath
  logic [XLEN-1:0]      divisor_q;
  logic [XLEN-1:0]      quot_q;
  logic [XLEN-1:0]      rem_q;
  logic [XLEN:0]        rem_shift;
  logic [XLEN+1:0]      trial;
  logic                 ge;

  // Sign correction
  logic                 q_neg_q;
  logic                 r_neg_q;
  logic                 is_rem_q;
  logic [XLEN-1:0]      quot_fix;
  logic [XLEN-1:0]      rem_fix;

  assign op_signed = (operator_i == DIV_S) || (operator_i == REM_S);
  assign a_neg     = op_signed && op_a_i[XLEN-1];
  assign b_neg     = op_signed && op_b_i[XLEN-1];
  assign abs_a     = a_neg ? -op_a_i : op_a_i;
  assign abs_b     = b_neg ? -op_b_i : op_b_i;
  assign div_zero  = (op_b_i == '0);

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  assign last = (cnt_q == DIV_CNT_W'(DIV_CYCLES - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Zero divisor needs no iterations
      IDLE: if (valid_i) state_d = div_zero ? DONE : RUN;
      RUN: begin
        if (!valid_i) begin
          state_d = IDLE;
        end else if (last) begin
          state_d = DONE;
        end
      end
      DONE: if (ready_i || !valid_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == RUN) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Restoring shift-subtract on magnitudes
  ////////////////////////////////////////////////////////////

  // Dividend bits leave the top of quot_q as quotient bits enter below
  assign rem_shift = {rem_q, quot_q[XLEN-1]};
  assign trial     = {1'b0, rem_shift} - {2'b00, divisor_q};
  assign ge        = !trial[XLEN+1];

  always_ff @(posedge clk) begin
    if (state_q == IDLE && valid_i) begin
      divisor_q <= abs_b;
      // Divide by zero preloads the final answer
      quot_q    <= div_zero ? '1 : abs_a;
      rem_q     <= div_zero ? abs_a : '0;
      q_neg_q   <= (a_neg ^ b_neg) && !div_zero;
      r_neg_q   <= a_neg;
      is_rem_q  <= (operator_i == REM_S) || (operator_i == REM_U);
    end else if (state_q == RUN) begin
      quot_q <= {quot_q[XLEN-2:0], ge};
      rem_q  <= ge ? trial[XLEN-1:0] : rem_shift[XLEN-1:0];
    end
  end

  // Quotient sign from both operands, remainder follows dividend
  // MIN / -1 wraps back to MIN with a zero remainder
  assign quot_fix = q_neg_q ? -quot_q : quot_q;
  assign rem_fix  = r_neg_q ? -rem_q : rem_q;
  assign result_o = is_rem_q ? rem_fix : quot_fix;

  assign valid_o = (state_q == DONE);
  assign ready_o = (state_q == IDLE && !valid_i) || (state_q == DONE && ready_i);

endmodule

//--- ex_mult.sv
`timescale 1ns/1ps

module ex_mult import isa_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  input  mul_op_e         operator_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,

  output logic [XLEN-1:0] result_o,

  input  logic            valid_i,
  output logic            ready_o,
  output logic            valid_o,
  input  logic            ready_i
);

  typedef enum logic {
    IDLE,
    DONE
  } mul_state_e;

  mul_state_e             state_q;
  mul_state_e             state_d;
  logic                   a_signed;
  logic                   b_signed;
  // Operands widened by one bit so one signed multiply covers all modes
  logic signed [XLEN:0]   op_a_q;
  logic signed [XLEN:0]   op_b_q;
  logic                   high_q;
  logic signed [2*XLEN+1:0] product;

  // MULH signed x signed, MULHSU signed x unsigned, MULHU unsigned
  assign a_signed = (operator_i == MUL_H) || (operator_i == MUL_HSU);
  assign b_signed = (operator_i == MUL_H);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (valid_i) state_d = DONE;
      // Leave on hand-off, or when the request went away
      DONE: if (ready_i || !valid_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // First cycle captures the extended operands
  always_ff @(posedge clk) begin
    if (state_q == IDLE && valid_i) begin
      op_a_q <= {a_signed & op_a_i[XLEN-1], op_a_i};
      op_b_q <= {b_signed & op_b_i[XLEN-1], op_b_i};
      high_q <= (operator_i != MUL_L);
    end
  end

  // Second cycle forms the product, stable while in DONE
  assign product  = op_a_q * op_b_q;
  assign result_o = high_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

  assign valid_o = (state_q == DONE);
  assign ready_o = (state_q == IDLE && !valid_i) || (state_q == DONE && ready_i);

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // From decode
  input  id_ex_pipe_t     id_ex_i,
  input  ctrl_t           ctrl_i,

  // To writeback
  output ex_wb_pipe_t     ex_wb_o,
  input  logic            wb_ready_i,

  output logic            ex_ready_o,

  // Branch resolution
  output logic            branch_decision_o,
  output logic [XLEN-1:0] branch_target_o
);

  logic            live;
  logic            exc_flag;
  logic            alu_en_gated;
  logic            mul_en_gated;
  logic            div_en_gated;

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic            alu_valid;
  logic            alu_ready;
  logic [XLEN-1:0] mul_result;
  logic            mul_valid;
  logic            mul_ready;
  logic [XLEN-1:0] div_result;
  logic            div_valid;
  logic            div_ready;

  logic [XLEN-1:0] ex_result;
  logic            unit_valid;
  logic            ex_valid;

  // EX/WB register
  ex_wb_pipe_t     ex_wb_q;

  // Instruction present and not being killed
  assign live     = id_ex_i.instr_valid && !ctrl_i.kill_ex;
  // Flagged instructions bypass the units
  assign exc_flag = id_ex_i.illegal_insn || id_ex_i.ecall_insn || id_ex_i.ebrk_insn;

  assign alu_en_gated = id_ex_i.alu_en && live && !exc_flag;
  assign mul_en_gated = id_ex_i.mul_en && live && !exc_flag;
  assign div_en_gated = id_ex_i.div_en && live && !exc_flag;

  ////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .operator_i   (id_ex_i.alu_operator),
    .operand_a_i  (id_ex_i.operand_a),
    .operand_b_i  (id_ex_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp),
    .valid_i      (alu_en_gated),
    .ready_o      (alu_ready),
    .valid_o      (alu_valid),
    .ready_i      (wb_ready_i)
  );

  ex_mult mult_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (id_ex_i.mul_operator),
    .op_a_i     (id_ex_i.operand_a),
    .op_b_i     (id_ex_i.operand_b),
    .result_o   (mul_result),
    .valid_i    (mul_en_gated),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid),
    .ready_i    (wb_ready_i)
  );

  ex_div div_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (id_ex_i.div_operator),
    .op_a_i     (id_ex_i.operand_a),
    .op_b_i     (id_ex_i.operand_b),
    .result_o   (div_result),
    .valid_i    (div_en_gated),
    .ready_o    (div_ready),
    .valid_o    (div_valid),
    .ready_i    (wb_ready_i)
  );

  // Divider result takes priority over multiplier and ALU
  always_comb begin
    if (id_ex_i.div_en) begin
      ex_result  = div_result;
      unit_valid = div_valid;
    end else if (id_ex_i.mul_en) begin
      ex_result  = mul_result;
      unit_valid = mul_valid;
    end else begin
      ex_result  = alu_result;
      unit_valid = alu_valid;
    end
  end

  // Halt blocks the hand-off so the held instruction is not loaded twice
  assign ex_valid = (unit_valid || exc_flag) && live && !ctrl_i.halt_ex;

  // Kill drains EX at once and otherwise EX waits for every unit and WB
  assign ex_ready_o = ctrl_i.kill_ex ||
                      (alu_ready && mul_ready && div_ready && wb_ready_i && !ctrl_i.halt_ex);

  assign branch_decision_o = alu_cmp;
  assign branch_target_o   = id_ex_i.operand_c;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  // Load on valid, bubble on empty slot, hold while WB is stalled
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_q <= '0;
    end else if (wb_ready_i) begin
      if (ex_valid) begin
        ex_wb_q <= '{
          instr_valid:  1'b1,
          pc:           id_ex_i.pc,
          rf_we:        id_ex_i.rf_we,
          rf_waddr:     id_ex_i.rf_waddr,
          rf_wdata:     ex_result,
          illegal_insn: id_ex_i.illegal_insn,
          ecall_insn:   id_ex_i.ecall_insn,
          ebrk_insn:    id_ex_i.ebrk_insn
        };
      end else begin
        ex_wb_q.instr_valid <= 1'b0;
      end
    end
  end

  assign ex_wb_o = ex_wb_q;

endmodule

//--- exec_core.f
isa_pkg.sv
pipe_pkg.sv
ex_alu.sv
ex_mult.sv
ex_div.sv
ex_stage.sv
wb_stage.sv
exec_core.sv
tb_exec_core.sv

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core import isa_pkg::*, pipe_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // Decode side
  input  id_ex_pipe_t     id_ex_i,
  input  ctrl_t           ctrl_i,
  output logic            ex_ready_o,

  // Branch resolution
  output logic            branch_decision_o,
  output logic [XLEN-1:0] branch_target_o,

  // Retire side
  output logic            retire_valid_o,
  output retire_t         retire_o,
  input  logic            retire_ready_i
);

  ex_wb_pipe_t ex_wb;
  logic        wb_ready;

  ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_i           (id_ex_i),
    .ctrl_i            (ctrl_i),
    .ex_wb_o           (ex_wb),
    .wb_ready_i        (wb_ready),
    .ex_ready_o        (ex_ready_o),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o)
  );

  wb_stage wb_stage_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_wb_i        (ex_wb),
    .wb_ready_o     (wb_ready),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .retire_ready_i (retire_ready_i)
  );

endmodule

//--- isa_pkg.sv
package isa_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath geometry
  ////////////////////////////////////////////////////////////

  // Integer register width
  localparam int unsigned XLEN       = 32;
  // Register index width
  localparam int unsigned REG_ADDR_W = 5;
  // Shift amount width
  localparam int unsigned SHAMT_W    = $clog2(XLEN);

  // One quotient bit per iteration
  localparam int unsigned DIV_CYCLES = 32;
  localparam int unsigned DIV_CNT_W  = $clog2(DIV_CYCLES);

  ////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////

  // ALU operators
  // Upper six codes are the branch comparisons
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Multiplier operators, low word or one of three high-word modes
  typedef enum logic [1:0] {
    MUL_L   = 2'b00,
    MUL_H   = 2'b01,
    MUL_HSU = 2'b10,
    MUL_HU  = 2'b11
  } mul_op_e;

  // Divider operators
  typedef enum logic [1:0] {
    DIV_S = 2'b00,
    DIV_U = 2'b01,
    REM_S = 2'b10,
    REM_U = 2'b11
  } div_op_e;

  // Cause reported with a retired instruction
  typedef enum logic [1:0] {
    EXC_NONE    = 2'b00,
    EXC_ILLEGAL = 2'b01,
    EXC_ECALL   = 2'b10,
    EXC_EBREAK  = 2'b11
  } exc_cause_e;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

  import isa_pkg::*;

  ////////////////////////////////////////////////////////////
  // Stage-to-stage records
  ////////////////////////////////////////////////////////////

  // Decoded instruction as handed from ID to EX
  typedef struct packed {
    logic                  instr_valid;
    logic [XLEN-1:0]       pc;
    // Functional unit selects
    logic                  alu_en;
    logic                  mul_en;
    logic                  div_en;
    alu_op_e               alu_operator;
    mul_op_e               mul_operator;
    div_op_e               div_operator;
    // Source operands, operand_c carries the branch target
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;
    // Destination
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    // Exception flags raised upstream
    logic                  illegal_insn;
    logic                  ecall_insn;
    logic                  ebrk_insn;
  } id_ex_pipe_t;

  // Executed instruction held in the EX/WB register
  typedef struct packed {
    logic                  instr_valid;
    logic [XLEN-1:0]       pc;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  illegal_insn;
    logic                  ecall_insn;
    logic                  ebrk_insn;
  } ex_wb_pipe_t;

  // Record presented at the retire port
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    exc_cause_e            cause;
  } retire_t;

  // Controller commands to EX
  typedef struct packed {
    // Drop the instruction in EX
    logic kill_ex;
    // Stall EX without dropping
    logic halt_ex;
  } ctrl_t;

endpackage

//--- tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core import isa_pkg::*, pipe_pkg::*; ();

  logic            clk = 1'b0;
  logic            rst_n;
  id_ex_pipe_t     id_ex_i;
  ctrl_t           ctrl_i;
  logic            retire_ready_i;
  logic            ex_ready_o;
  logic            branch_decision_o;
  logic [XLEN-1:0] branch_target_o;
  logic            retire_valid_o;
  retire_t         retire_o;

  // Random stall source for the retire port
  logic            bp_en;
  logic            bp_rand;

  // Scoreboard state
  retire_t         exp_q[$];
  retire_t         exp_rec;
  retire_t         held_rec;
  logic            held_valid;
  logic [31:0]     pc_cnt;
  int              err_cnt;
  int              chk_cnt;
  int              test_cnt;

  exec_core dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_i           (id_ex_i),
    .ctrl_i            (ctrl_i),
    .ex_ready_o        (ex_ready_o),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o),
    .retire_valid_o    (retire_valid_o),
    .retire_o          (retire_o),
    .retire_ready_i    (retire_ready_i)
  );

  // 40 ns period
  always #20 clk = ~clk;

  always @(posedge clk) begin
    #2;
    bp_rand = 1'($urandom % 2);
  end

  assign retire_ready_i = bp_en ? bp_rand : 1'b1;

  ////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
      ALU_SLT:  return {31'h0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'h0, a < b};
      default:  return 32'h0;
    endcase
  endfunction

  function automatic logic cmp_model(input alu_op_e op, input logic [31:0] a,
                                     input logic [31:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Operands extended by their signedness give an exact low 64 bits
  function automatic logic [31:0] mul_model(input mul_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = (op == MUL_H || op == MUL_HSU) ? {{32{a[31]}}, a} : {32'h0, a};
    eb = (op == MUL_H) ? {{32{b[31]}}, b} : {32'h0, b};
    p  = ea * eb;
    return (op == MUL_L) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic [31:0] div_model(input div_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic is_signed;
    is_signed = (op == DIV_S) || (op == REM_S);
    // Divide by zero gives all ones as quotient and the dividend as remainder
    if (b == 32'h0) begin
      return (op == DIV_S || op == DIV_U) ? 32'hffff_ffff : a;
    end
    // Signed overflow
    if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return (op == DIV_S) ? a : 32'h0;
    end
    case (op)
      DIV_S:   return 32'($signed(a) / $signed(b));
      REM_S:   return 32'($signed(a) % $signed(b));
      DIV_U:   return a / b;
      default: return a % b;
    endcase
  endfunction

  // Record the retire port should show for an instruction
  function automatic retire_t build_record(input id_ex_pipe_t insn, input logic [31:0] data);
    retire_t r;
    r.pc       = insn.pc;
    r.rf_waddr = insn.rf_waddr;
    r.rf_wdata = data;
    if (insn.illegal_insn) begin
      r.cause = EXC_ILLEGAL;
    end else if (insn.ecall_insn) begin
      r.cause = EXC_ECALL;
    end else if (insn.ebrk_insn) begin
      r.cause = EXC_EBREAK;
    end else begin
      r.cause = EXC_NONE;
    end
    r.rf_we = insn.rf_we && (r.cause == EXC_NONE) && (insn.rf_waddr != 5'd0);
    return r;
  endfunction

  // Fresh instruction at the next pc with no unit selected
  function automatic id_ex_pipe_t make_insn(input logic [31:0] a, input logic [31:0] b);
    id_ex_pipe_t t;
    t             = '0;
    t.instr_valid = 1'b1;
    t.pc          = pc_cnt;
    t.operand_a   = a;
    t.operand_b   = b;
    t.operand_c   = pc_cnt ^ 32'h0000_4a0c;
    t.rf_we       = 1'b1;
    t.rf_waddr    = pc_cnt[6:2] | 5'd1;
    pc_cnt        = pc_cnt + 32'd4;
    return t;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and handshakes
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $finish;
  endtask

  // Present one instruction and hold it until EX accepts it
  task automatic issue(input id_ex_pipe_t insn, input logic [31:0] data,
                       input logic expect_retire);
    int waited;
    waited  = 0;
    id_ex_i = insn;
    @(negedge clk);
    while (!ex_ready_o) begin
      waited++;
      if (waited >= 100) begin
        abort_run("timeout: ex_ready_o stayed low for 100 cycles");
      end
      @(negedge clk);
    end
    if (expect_retire) begin
      exp_q.push_back(build_record(insn, data));
    end
    @(posedge clk);
    #2;
    id_ex_i = '0;
  endtask

  // Wait for every expected record to leave the retire port
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited >= 100) begin
        abort_run("timeout: expected retire records did not arrive in 100 cycles");
      end
    end
    @(posedge clk);
    #2;
  endtask

  task automatic end_test(input string name, input int err_before);
    drain();
    test_cnt++;
    $display("%s test done, %0d errors", name, err_cnt - err_before);
  endtask

  // Retire collector
  // A record counts when valid and ready meet at the next edge
  always @(negedge clk) begin
    if (rst_n && retire_valid_o) begin
      if (held_valid) begin
        check_word("held retire_o pc", retire_o.pc, held_rec.pc);
        check_word("held retire_o rf_we", 32'(retire_o.rf_we), 32'(held_rec.rf_we));
        check_word("held retire_o rf_waddr", 32'(retire_o.rf_waddr), 32'(held_rec.rf_waddr));
        check_word("held retire_o wdata", retire_o.rf_wdata, held_rec.rf_wdata);
        check_word("held retire_o cause", 32'(retire_o.cause), 32'(held_rec.cause));
      end
      if (retire_ready_i) begin
        held_valid = 1'b0;
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("error at %0t: retire of pc %h that was not expected", $time, retire_o.pc);
        end else begin
          exp_rec = exp_q.pop_front();
          check_word("retire pc", retire_o.pc, exp_rec.pc);
          check_word("retire rf_we", 32'(retire_o.rf_we), 32'(exp_rec.rf_we));
          check_word("retire rf_waddr", 32'(retire_o.rf_waddr), 32'(exp_rec.rf_waddr));
          check_word("retire cause", 32'(retire_o.cause), 32'(exp_rec.cause));
          if (exp_rec.rf_we) begin
            check_word("retire rf_wdata", retire_o.rf_wdata, exp_rec.rf_wdata);
          end
        end
      end else begin
        held_valid = 1'b1;
        held_rec   = retire_o;
      end
    end else begin
      held_valid = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic alu_test();
    int          e0;
    id_ex_pipe_t insn;
    alu_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    e0 = err_cnt;
    for (int i = 0; i < 16; i++) begin
      op = alu_op_e'(i);
      for (int rep = 0; rep < 4; rep++) begin
        a = $urandom;
        // Equal operands on the first pass exercise EQ and GE
        b = (rep == 0) ? a : $urandom;
        insn = make_insn(a, b);
        insn.alu_en       = 1'b1;
        insn.alu_operator = op;
        if (i >= 10) begin
          // Branches write no register
          insn.rf_we = 1'b0;
          id_ex_i    = insn;
          #5;
          check_word("branch_decision_o", 32'(branch_decision_o), 32'(cmp_model(op, a, b)));
          check_word("branch_target_o", branch_target_o, insn.operand_c);
        end
        issue(insn, alu_model(op, a, b), 1'b1);
      end
    end
    end_test("alu", e0);
  endtask

  function automatic logic [31:0] corner_val(input int k);
    case (k)
      0:       return 32'h0;
      1:       return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  task automatic mul_test();
    int          e0;
    id_ex_pipe_t insn;
    mul_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    e0 = err_cnt;
    for (int i = 0; i < 4; i++) begin
      op = mul_op_e'(i);
      // Nine corner pairs before the random operands
      for (int k = 0; k < 13; k++) begin
        a = (k < 9) ? corner_val(k / 3) : $urandom;
        b = (k < 9) ? corner_val(k % 3) : $urandom;
        insn = make_insn(a, b);
        insn.mul_en       = 1'b1;
        insn.mul_operator = op;
        issue(insn, mul_model(op, a, b), 1'b1);
      end
    end
    end_test("multiply", e0);
  endtask

  task automatic div_test();
    int          e0;
    id_ex_pipe_t insn;
    div_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    e0 = err_cnt;
    for (int i = 0; i < 4; i++) begin
      op = div_op_e'(i);
      for (int k = 0; k < 7; k++) begin
        a = $urandom;
        b = (k == 0) ? 32'h0 : ((k == 1) ? 32'hffff_ffff : $urandom >> (k * 4));
        // Overflow case for the signed operators
        if (k == 1) begin
          a = 32'h8000_0000;
        end
        insn = make_insn(a, b);
        insn.div_en       = 1'b1;
        insn.div_operator = op;
        issue(insn, div_model(op, a, b), 1'b1);
        // Alternate with an ALU add so retire order is checked
        insn = make_insn(a, b);
        insn.alu_en = 1'b1;
        issue(insn, a + b, 1'b1);
      end
    end
    end_test("divide", e0);
  endtask

  task automatic backpressure_test();
    int          e0;
    id_ex_pipe_t insn;
    logic [31:0] a;
    logic [31:0] b;
    e0    = err_cnt;
    bp_en = 1'b1;
    for (int n = 0; n < 24; n++) begin
      a    = $urandom;
      b    = $urandom;
      insn = make_insn(a, b);
      if (n % 3 == 2) begin
        insn.mul_en = 1'b1;
        issue(insn, mul_model(MUL_L, a, b), 1'b1);
      end else begin
        insn.alu_en       = 1'b1;
        insn.alu_operator = ALU_XOR;
        issue(insn, a ^ b, 1'b1);
      end
    end
    drain();
    bp_en = 1'b0;
    end_test("back-pressure", e0);
  endtask

  task automatic control_test();
    int          e0;
    id_ex_pipe_t insn;
    e0 = err_cnt;
    // Killed instruction is taken at once and never retires
    insn = make_insn(32'h11, 32'h22);
    insn.alu_en    = 1'b1;
    ctrl_i.kill_ex = 1'b1;
    issue(insn, 32'h0, 1'b0);
    ctrl_i.kill_ex = 1'b0;
    drain();
    repeat (5) @(posedge clk);
    #2;
    // Halt holds the instruction in EX
    insn = make_insn(32'h33, 32'h44);
    insn.alu_en    = 1'b1;
    ctrl_i.halt_ex = 1'b1;
    id_ex_i        = insn;
    for (int c = 0; c < 8; c++) begin
      @(negedge clk);
      check_word("ex_ready_o under halt", 32'(ex_ready_o), 32'h0);
      check_word("retire_valid_o under halt", 32'(retire_valid_o), 32'h0);
    end
    @(posedge clk);
    #2;
    ctrl_i.halt_ex = 1'b0;
    issue(insn, 32'h77, 1'b1);
    end_test("control", e0);
  endtask

  task automatic exception_test();
    int          e0;
    id_ex_pipe_t insn;
    e0 = err_cnt;
    // Flag sets in the order illegal, ecall, ebreak
    for (int f = 1; f < 8; f++) begin
      insn = make_insn($urandom, $urandom);
      insn.illegal_insn = f[0];
      insn.ecall_insn   = f[1];
      insn.ebrk_insn    = f[2];
      // Flagged multiply must skip the unit
      insn.mul_en       = (f == 6);
      insn.alu_en       = (f != 6);
      issue(insn, 32'h0, 1'b1);
    end
    // Write to x0
    insn = make_insn(32'h5, 32'h6);
    insn.alu_en   = 1'b1;
    insn.rf_waddr = 5'd0;
    issue(insn, 32'hb, 1'b1);
    end_test("exception", e0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(23187));
    rst_n      = 1'b0;
    id_ex_i    = '0;
    ctrl_i     = '0;
    bp_en      = 1'b0;
    held_valid = 1'b0;
    pc_cnt     = 32'h0000_1000;
    err_cnt    = 0;
    chk_cnt    = 0;
    test_cnt   = 0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    alu_test();
    mul_test();
    div_test();
    backpressure_test();
    control_test();
    exception_test();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- wb_stage.sv
`timescale 1ns/1ps

module wb_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // From EX/WB register
  input  ex_wb_pipe_t ex_wb_i,
  output logic        wb_ready_o,

  // Retire port
  output logic        retire_valid_o,
  output retire_t     retire_o,
  input  logic        retire_ready_i
);

  exc_cause_e cause;
  logic       load;
  logic       wr_en;

  // Cause priority illegal, then ecall, then ebreak
  always_comb begin
    if (ex_wb_i.illegal_insn) begin
      cause = EXC_ILLEGAL;
    end else if (ex_wb_i.ecall_insn) begin
      cause = EXC_ECALL;
    end else if (ex_wb_i.ebrk_insn) begin
      cause = EXC_EBREAK;
    end else begin
      cause = EXC_NONE;
    end
  end

  // No write for flagged instructions or for x0
  assign wr_en = ex_wb_i.rf_we && (cause == EXC_NONE) && (ex_wb_i.rf_waddr != '0);

  // Free when empty or the current record is taken this cycle
  assign wb_ready_o = !retire_valid_o || retire_ready_i;
  assign load       = wb_ready_o && ex_wb_i.instr_valid;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      retire_valid_o <= 1'b0;
    end else if (wb_ready_o) begin
      retire_valid_o <= ex_wb_i.instr_valid;
    end
  end

  // Record stays put while the retire port is stalled
  always_ff @(posedge clk) begin
    if (load) begin
      retire_o <= '{
        pc:       ex_wb_i.pc,
        rf_we:    wr_en,
        rf_waddr: ex_wb_i.rf_waddr,
        rf_wdata: ex_wb_i.rf_wdata,
        cause:    cause
      };
    end
  end

endmodule
